// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_mips_control
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+hdl
hdl/ctrl_pkg.sv
hdl/ctrl_if.sv
hdl/instr_decoder.sv
hdl/state_sequencer.sv
hdl/datapath_ctrl.sv
hdl/mem_ctrl.sv
hdl/mips_control.sv
testbench/tb_mips_control.sv

// ==== hdl/ctrl_config.svh ====
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// Instruction field widths.
`define OPCODE_W    6
`define FUNCT_W     6
`define RT_W        5

// Datapath select widths.
`define SRC_A_W     2
`define SRC_B_W     3
`define PC_SRC_W    2
`define REG_DST_W   2
`define WB_SEL_W    2
`define EXT_W       2
`define MASK_W      3

// ########################################
// Primary opcodes.
// ########################################
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011

// ########################################
// Function codes under OP_SPECIAL.
// ########################################
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_JR       6'b001000
`define FN_ADDU     6'b100001
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

// Rt codes under OP_REGIMM.
`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001

`endif

// ==== hdl/ctrl_if.sv ====
`timescale 1ns/10ps

interface ctrl_if (input logic clk);
    import ctrl_pkg::*;

    state_e       state;
    instr_e       instr;
    instr_class_e iclass;
    // Compare result from the datapath.
    logic [1:0]   cond;

    modport seq (output state, input iclass);

    modport dec (output instr, output iclass, input state);

    modport gen (input clk, input state, input instr, input iclass, input cond);

endinterface

// ==== hdl/ctrl_pkg.sv ====
package ctrl_pkg;

    // ########################################
    // Sequencer states, one clock each.
    // ########################################
    typedef enum logic [2:0] {
        S_FETCH     = 3'd0,
        S_DECODE    = 3'd1,
        S_EXECUTE   = 3'd2,
        S_MEMORY    = 3'd3,
        S_WRITEBACK = 3'd4
    } state_e;

    // Decoded instruction.
    typedef enum logic [5:0] {
        I_NOP,
        // R-type ALU.
        I_ADDU, I_SUBU, I_AND, I_OR, I_XOR, I_SLT, I_SLTU,
        // Immediate ALU.
        I_ADDIU, I_ANDI, I_ORI, I_XORI, I_SLTI, I_SLTIU, I_LUI,
        // Shifts.
        I_SLL, I_SRL, I_SRA, I_SLLV, I_SRLV, I_SRAV,
        // Loads and stores.
        I_LW, I_LB, I_LBU, I_LH, I_LHU, I_SW, I_SB, I_SH,
        // Branches and jumps.
        I_BEQ, I_BNE, I_BGEZ, I_BLTZ, I_BGTZ, I_BLEZ, I_J, I_JR
    } instr_e;

    // Instruction class, picks the state path.
    typedef enum logic [2:0] {
        C_ALU_R,
        C_ALU_I,
        C_SHIFT,
        C_LOAD,
        C_STORE,
        C_BRANCH,
        C_JUMP,
        C_NOP
    } instr_class_e;

    // ALU operation codes.
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SRA = 4'd7
    } alu_op_e;

endpackage

// ==== hdl/datapath_ctrl.sv ====
`timescale 1ns/10ps
`include "ctrl_config.svh"

module datapath_ctrl (
    input  logic                    reset,
    ctrl_if.gen                     ctrl,
    output logic                    ir_write,
    output logic                    pc_write,
    output logic                    alt_pc_write,
    output logic [`PC_SRC_W-1:0]    pc_src,
    output logic                    reg_write,
    output logic [`REG_DST_W-1:0]   reg_dst,
    output logic [`WB_SEL_W-1:0]    mem_to_reg,
    output logic [`SRC_A_W-1:0]     alu_src_a,
    output logic [`SRC_B_W-1:0]     alu_src_b,
    output ctrl_pkg::alu_op_e       alu_op,
    output logic [`EXT_W-1:0]       ext_mode,
    output logic                    shift_swap,
    output logic                    bool_set
);
    import ctrl_pkg::*;

    logic slt_family;

    assign slt_family = ctrl.instr inside {I_SLT, I_SLTU, I_SLTI, I_SLTIU};

    always_comb begin
        ir_write     = 1'b0;
        pc_write     = 1'b0;
        alt_pc_write = 1'b0;
        pc_src       = '0;
        reg_write    = 1'b0;
        reg_dst      = '0;
        mem_to_reg   = '0;
        alu_src_a    = '0;
        alu_src_b    = '0;
        alu_op       = ALU_ADD;
        shift_swap   = 1'b0;
        bool_set     = 1'b0;
        case (ctrl.state)
            S_FETCH: begin
                ir_write  = 1'b1;
                pc_write  = 1'b1;
                alu_src_b = `SRC_B_W'(1);
            end
            S_DECODE: begin
                // Branch target precompute.
                alu_src_b = `SRC_B_W'(3);
                pc_src    = `PC_SRC_W'(2);
            end
            S_EXECUTE: begin
                pc_src    = `PC_SRC_W'(1);
                alu_src_a = (ctrl.instr == I_LUI) ? `SRC_A_W'(2) : `SRC_A_W'(1);
                case (ctrl.instr)
                    I_SLL, I_SRA, I_SRL:    alu_src_b = `SRC_B_W'(4);
                    I_SLLV, I_SRAV, I_SRLV: alu_src_b = `SRC_B_W'(5);
                    I_JR:                   alu_src_b = `SRC_B_W'(6);
                    default: begin
                        if (ctrl.iclass inside {C_ALU_I, C_LOAD, C_STORE}) begin
                            alu_src_b = `SRC_B_W'(2);
                        end
                    end
                endcase
                case (ctrl.instr)
                    I_AND, I_ANDI:  alu_op = ALU_AND;
                    I_OR, I_ORI:    alu_op = ALU_OR;
                    I_XOR, I_XORI:  alu_op = ALU_XOR;
                    I_SLL, I_SLLV:  alu_op = ALU_SLL;
                    I_SRL, I_SRLV:  alu_op = ALU_SRL;
                    I_SRA, I_SRAV:  alu_op = ALU_SRA;
                    default: begin
                        if (slt_family || ctrl.instr == I_SUBU || ctrl.iclass == C_BRANCH) begin
                            alu_op = ALU_SUB;
                        end
                    end
                endcase
                shift_swap   = ctrl.iclass == C_SHIFT;
                alt_pc_write = ctrl.iclass inside {C_BRANCH, C_JUMP};
                bool_set     = slt_family && (ctrl.cond == 2'b01);
            end
            S_WRITEBACK: begin
                reg_write = 1'b1;
                reg_dst   = (ctrl.iclass inside {C_ALU_R, C_SHIFT}) ? `REG_DST_W'(1) : '0;
                if (ctrl.iclass == C_LOAD) begin
                    mem_to_reg = `WB_SEL_W'(1);
                end else if (slt_family) begin
                    mem_to_reg = `WB_SEL_W'(2);
                end
            end
            default: ;
        endcase
        // Enables stay low while in reset.
        if (reset) begin
            ir_write     = 1'b0;
            pc_write     = 1'b0;
            alt_pc_write = 1'b0;
            reg_write    = 1'b0;
            bool_set     = 1'b0;
        end
    end

    // Immediate extension for the instruction in flight, none before execute.
    always_comb begin
        ext_mode = '0;
        if (ctrl.state inside {S_EXECUTE, S_MEMORY, S_WRITEBACK}) begin
            if (ctrl.instr == I_LUI) begin
                ext_mode = `EXT_W'(3);
            end else if (ctrl.instr inside {I_ADDIU, I_SLTI, I_SLTIU} ||
                         ctrl.iclass inside {C_LOAD, C_STORE, C_BRANCH}) begin
                ext_mode = `EXT_W'(2);
            end
        end
    end

endmodule

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/10ps
`include "ctrl_config.svh"

module instr_decoder (
    input logic                 clk,
    input logic                 reset,
    input logic [`OPCODE_W-1:0] ir_opcode,
    input logic [`FUNCT_W-1:0]  ir_function,
    input logic [`RT_W-1:0]     ir_rt,
    ctrl_if.dec                 ctrl
);
    import ctrl_pkg::*;

    instr_e       instr_d;
    instr_class_e class_d;

    // Field match.
    always_comb begin
        instr_d = I_NOP;
        case (ir_opcode)
            `OP_SPECIAL: begin
                case (ir_function)
                    `FN_ADDU: instr_d = I_ADDU;
                    `FN_SUBU: instr_d = I_SUBU;
                    `FN_AND:  instr_d = I_AND;
                    `FN_OR:   instr_d = I_OR;
                    `FN_XOR:  instr_d = I_XOR;
                    `FN_SLT:  instr_d = I_SLT;
                    `FN_SLTU: instr_d = I_SLTU;
                    `FN_SLL:  instr_d = I_SLL;
                    `FN_SRL:  instr_d = I_SRL;
                    `FN_SRA:  instr_d = I_SRA;
                    `FN_SLLV: instr_d = I_SLLV;
                    `FN_SRLV: instr_d = I_SRLV;
                    `FN_SRAV: instr_d = I_SRAV;
                    `FN_JR:   instr_d = I_JR;
                    default:  instr_d = I_NOP;
                endcase
            end
            `OP_REGIMM: begin
                case (ir_rt)
                    `RT_BLTZ: instr_d = I_BLTZ;
                    `RT_BGEZ: instr_d = I_BGEZ;
                    default:  instr_d = I_NOP;
                endcase
            end
            `OP_J:     instr_d = I_J;
            `OP_BEQ:   instr_d = I_BEQ;
            `OP_BNE:   instr_d = I_BNE;
            `OP_BLEZ:  instr_d = I_BLEZ;
            `OP_BGTZ:  instr_d = I_BGTZ;
            `OP_ADDIU: instr_d = I_ADDIU;
            `OP_SLTI:  instr_d = I_SLTI;
            `OP_SLTIU: instr_d = I_SLTIU;
            `OP_ANDI:  instr_d = I_ANDI;
            `OP_ORI:   instr_d = I_ORI;
            `OP_XORI:  instr_d = I_XORI;
            `OP_LUI:   instr_d = I_LUI;
            `OP_LB:    instr_d = I_LB;
            `OP_LH:    instr_d = I_LH;
            `OP_LW:    instr_d = I_LW;
            `OP_LBU:   instr_d = I_LBU;
            `OP_LHU:   instr_d = I_LHU;
            `OP_SB:    instr_d = I_SB;
            `OP_SH:    instr_d = I_SH;
            `OP_SW:    instr_d = I_SW;
            default:   instr_d = I_NOP;
        endcase
    end

    always_comb begin
        case (instr_d)
            I_ADDU, I_SUBU, I_AND, I_OR, I_XOR, I_SLT, I_SLTU:         class_d = C_ALU_R;
            I_ADDIU, I_ANDI, I_ORI, I_XORI, I_SLTI, I_SLTIU, I_LUI:    class_d = C_ALU_I;
            I_SLL, I_SRL, I_SRA, I_SLLV, I_SRLV, I_SRAV:               class_d = C_SHIFT;
            I_LW, I_LB, I_LBU, I_LH, I_LHU:                            class_d = C_LOAD;
            I_SW, I_SB, I_SH:                                          class_d = C_STORE;
            I_BEQ, I_BNE, I_BGEZ, I_BLTZ, I_BGTZ, I_BLEZ:              class_d = C_BRANCH;
            I_J, I_JR:                                                 class_d = C_JUMP;
            default:                                                   class_d = C_NOP;
        endcase
    end

    // Captured at the end of decode, held until the next one.
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.instr  <= I_NOP;
            ctrl.iclass <= C_NOP;
        end else if (ctrl.state == S_DECODE) begin
            ctrl.instr  <= instr_d;
            ctrl.iclass <= class_d;
        end
    end

endmodule

// ==== hdl/mem_ctrl.sv ====
`timescale 1ns/10ps
`include "ctrl_config.svh"

module mem_ctrl (
    input  logic                reset,
    ctrl_if.gen                 ctrl,
    output logic                mem_read,
    output logic                mem_write,
    output logic                i_or_d,
    output logic                byte_store_en,
    output logic                half_store_en,
    output logic [`MASK_W-1:0]  load_mask
);
    import ctrl_pkg::*;

    always_comb begin
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        i_or_d        = 1'b0;
        byte_store_en = 1'b0;
        half_store_en = 1'b0;
        load_mask     = '0;
        if (!reset) begin
            case (ctrl.state)
                S_FETCH: begin
                    mem_read = 1'b1;
                end
                S_MEMORY: begin
                    // Data address from the ALU result.
                    i_or_d        = 1'b1;
                    mem_read      = ctrl.iclass == C_LOAD;
                    mem_write     = ctrl.iclass == C_STORE;
                    byte_store_en = ctrl.instr == I_SB;
                    half_store_en = ctrl.instr == I_SH;
                end
                S_WRITEBACK: begin
                    if (ctrl.iclass == C_LOAD) begin
                        mem_read = 1'b1;
                        case (ctrl.instr)
                            I_LH:    load_mask = `MASK_W'(1);
                            I_LHU:   load_mask = `MASK_W'(2);
                            I_LB:    load_mask = `MASK_W'(3);
                            I_LBU:   load_mask = `MASK_W'(4);
                            default: load_mask = '0;
                        endcase
                    end
                end
                default: ;
            endcase
        end
    end

    a_rd_wr_excl: assert property (@(posedge ctrl.clk) disable iff (reset)
        !(mem_read && mem_write))
        else $error("memory read and write strobes overlap");

endmodule

// ==== hdl/mips_control.sv ====
`timescale 1ns/10ps
`include "ctrl_config.svh"

module mips_control (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`OPCODE_W-1:0]    ir_opcode,
    input  logic [`FUNCT_W-1:0]     ir_function,
    input  logic [`RT_W-1:0]        ir_rt,
    input  logic [1:0]              cond,
    output logic                    ir_write,
    output logic                    pc_write,
    output logic                    alt_pc_write,
    output logic [`PC_SRC_W-1:0]    pc_src,
    output logic                    reg_write,
    output logic [`REG_DST_W-1:0]   reg_dst,
    output logic [`WB_SEL_W-1:0]    mem_to_reg,
    output logic [`SRC_A_W-1:0]     alu_src_a,
    output logic [`SRC_B_W-1:0]     alu_src_b,
    output ctrl_pkg::alu_op_e       alu_op,
    output logic [`EXT_W-1:0]       ext_mode,
    output logic                    shift_swap,
    output logic                    bool_set,
    output logic                    mem_read,
    output logic                    mem_write,
    output logic                    i_or_d,
    output logic                    byte_store_en,
    output logic                    half_store_en,
    output logic [`MASK_W-1:0]      load_mask
);

    ctrl_if ctrl (.clk(clk));

    assign ctrl.cond = cond;

    // ########################################
    // Sequencing and decode.
    // ########################################
    state_sequencer i_state_sequencer (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl.seq)
    );

    instr_decoder i_instr_decoder (
        .clk         (clk),
        .reset       (reset),
        .ir_opcode   (ir_opcode),
        .ir_function (ir_function),
        .ir_rt       (ir_rt),
        .ctrl        (ctrl.dec)
    );

    // ########################################
    // Control generators.
    // ########################################
    datapath_ctrl i_datapath_ctrl (
        .reset        (reset),
        .ctrl         (ctrl.gen),
        .ir_write     (ir_write),
        .pc_write     (pc_write),
        .alt_pc_write (alt_pc_write),
        .pc_src       (pc_src),
        .reg_write    (reg_write),
        .reg_dst      (reg_dst),
        .mem_to_reg   (mem_to_reg),
        .alu_src_a    (alu_src_a),
        .alu_src_b    (alu_src_b),
        .alu_op       (alu_op),
        .ext_mode     (ext_mode),
        .shift_swap   (shift_swap),
        .bool_set     (bool_set)
    );

    mem_ctrl i_mem_ctrl (
        .reset         (reset),
        .ctrl          (ctrl.gen),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .i_or_d        (i_or_d),
        .byte_store_en (byte_store_en),
        .half_store_en (half_store_en),
        .load_mask     (load_mask)
    );

endmodule

// ==== hdl/state_sequencer.sv ====
`timescale 1ns/10ps

module state_sequencer (
    input logic clk,
    input logic reset,
    ctrl_if.seq ctrl
);
    import ctrl_pkg::*;

    state_e next_state;

    // ########################################
    // Next state.
    // ########################################
    always_comb begin
        case (ctrl.state)
            S_FETCH: begin
                next_state = S_DECODE;
            end
            S_DECODE: begin
                next_state = S_EXECUTE;
            end
            S_EXECUTE: begin
                case (ctrl.iclass)
                    C_LOAD, C_STORE:           next_state = S_MEMORY;
                    C_ALU_R, C_ALU_I, C_SHIFT: next_state = S_WRITEBACK;
                    default:                   next_state = S_FETCH;
                endcase
            end
            S_MEMORY: begin
                // Only loads write back.
                if (ctrl.iclass == C_LOAD) begin
                    next_state = S_WRITEBACK;
                end else begin
                    next_state = S_FETCH;
                end
            end
            default: begin
                next_state = S_FETCH;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.state <= S_FETCH;
        end else begin
            ctrl.state <= next_state;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        ctrl.state inside {S_FETCH, S_DECODE, S_EXECUTE, S_MEMORY, S_WRITEBACK})
        else $error("state left the legal set");

endmodule

// ==== testbench/tb_mips_control.sv ====
`timescale 1ns/10ps
`include "ctrl_config.svh"

module tb_mips_control;
    import ctrl_pkg::*;

    localparam int ENC_W       = `OPCODE_W + `FUNCT_W + `RT_W;
    localparam int N_RANDOM    = 16;
    localparam int N_INSTR     = 37 + N_RANDOM + 16;
    localparam int CYCLE_LIMIT = 5 * N_INSTR + 20;

    typedef struct packed {
        logic                   ir_write;
        logic                   pc_write;
        logic                   alt_pc_write;
        logic [`PC_SRC_W-1:0]   pc_src;
        logic                   reg_write;
        logic [`REG_DST_W-1:0]  reg_dst;
        logic [`WB_SEL_W-1:0]   mem_to_reg;
        logic [`SRC_A_W-1:0]    alu_src_a;
        logic [`SRC_B_W-1:0]    alu_src_b;
        alu_op_e                alu_op;
        logic [`EXT_W-1:0]      ext_mode;
        logic                   shift_swap;
        logic                   bool_set;
        logic                   mem_read;
        logic                   mem_write;
        logic                   i_or_d;
        logic                   byte_store_en;
        logic                   half_store_en;
        logic [`MASK_W-1:0]     load_mask;
    } ctrl_out_t;

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    logic [`OPCODE_W-1:0]   ir_opcode = '0;
    logic [`FUNCT_W-1:0]    ir_function = '0;
    logic [`RT_W-1:0]       ir_rt = '0;
    logic [1:0]             cond = '0;

    logic                   ir_write;
    logic                   pc_write;
    logic                   alt_pc_write;
    logic [`PC_SRC_W-1:0]   pc_src;
    logic                   reg_write;
    logic [`REG_DST_W-1:0]  reg_dst;
    logic [`WB_SEL_W-1:0]   mem_to_reg;
    logic [`SRC_A_W-1:0]    alu_src_a;
    logic [`SRC_B_W-1:0]    alu_src_b;
    alu_op_e                alu_op;
    logic [`EXT_W-1:0]      ext_mode;
    logic                   shift_swap;
    logic                   bool_set;
    logic                   mem_read;
    logic                   mem_write;
    logic                   i_or_d;
    logic                   byte_store_en;
    logic                   half_store_en;
    logic [`MASK_W-1:0]     load_mask;

    // Expected sequencer position from the cycle counts.
    state_e                 exp_state = S_FETCH;
    instr_e                 exp_instr = I_NOP;
    logic                   checking = 1'b0;
    string                  test_name = "reset";
    ctrl_out_t              exp_out;
    int                     cycle_count = 0;

    instr_e r_pool [0:12] = '{I_ADDU, I_SUBU, I_AND, I_OR, I_XOR, I_SLT, I_SLTU,
                              I_SLL, I_SRL, I_SRA, I_SLLV, I_SRLV, I_SRAV};
    instr_e slt_pool [0:3] = '{I_SLT, I_SLTU, I_SLTI, I_SLTIU};

    always #20 clk = ~clk;

    mips_control i_mips_control (.*);

    // ########################################
    // Reference model.
    // ########################################
    function automatic instr_class_e class_of(input instr_e ins);
        case (ins)
            I_ADDU, I_SUBU, I_AND, I_OR, I_XOR, I_SLT, I_SLTU:      return C_ALU_R;
            I_ADDIU, I_ANDI, I_ORI, I_XORI, I_SLTI, I_SLTIU, I_LUI: return C_ALU_I;
            I_SLL, I_SRL, I_SRA, I_SLLV, I_SRLV, I_SRAV:            return C_SHIFT;
            I_LW, I_LB, I_LBU, I_LH, I_LHU:                         return C_LOAD;
            I_SW, I_SB, I_SH:                                       return C_STORE;
            I_BEQ, I_BNE, I_BGEZ, I_BLTZ, I_BGTZ, I_BLEZ:           return C_BRANCH;
            I_J, I_JR:                                              return C_JUMP;
            default:                                                return C_NOP;
        endcase
    endfunction

    function automatic ctrl_out_t ref_ctrl(input instr_e ins, input state_e st,
                                           input logic [1:0] c, input logic rst);
        ctrl_out_t    o;
        instr_class_e cls;
        logic         slt_like;
        cls      = class_of(ins);
        slt_like = ins inside {I_SLT, I_SLTU, I_SLTI, I_SLTIU};
        o        = '0;
        case (st)
            S_FETCH: begin
                o.ir_write  = 1'b1;
                o.pc_write  = 1'b1;
                o.alu_src_b = `SRC_B_W'(1);
                o.mem_read  = 1'b1;
            end
            S_DECODE: begin
                o.alu_src_b = `SRC_B_W'(3);
                o.pc_src    = `PC_SRC_W'(2);
            end
            S_EXECUTE: begin
                o.pc_src    = `PC_SRC_W'(1);
                o.alu_src_a = (ins == I_LUI) ? `SRC_A_W'(2) : `SRC_A_W'(1);
                if (ins inside {I_SLL, I_SRL, I_SRA}) begin
                    o.alu_src_b = `SRC_B_W'(4);
                end else if (ins inside {I_SLLV, I_SRLV, I_SRAV}) begin
                    o.alu_src_b = `SRC_B_W'(5);
                end else if (ins == I_JR) begin
                    o.alu_src_b = `SRC_B_W'(6);
                end else if (cls inside {C_ALU_I, C_LOAD, C_STORE}) begin
                    o.alu_src_b = `SRC_B_W'(2);
                end
                if (ins inside {I_AND, I_ANDI}) o.alu_op = ALU_AND;
                else if (ins inside {I_OR, I_ORI}) o.alu_op = ALU_OR;
                else if (ins inside {I_XOR, I_XORI}) o.alu_op = ALU_XOR;
                else if (ins inside {I_SLL, I_SLLV}) o.alu_op = ALU_SLL;
                else if (ins inside {I_SRL, I_SRLV}) o.alu_op = ALU_SRL;
                else if (ins inside {I_SRA, I_SRAV}) o.alu_op = ALU_SRA;
                else if (slt_like || ins == I_SUBU || cls == C_BRANCH) o.alu_op = ALU_SUB;
                o.shift_swap   = (cls == C_SHIFT);
                o.alt_pc_write = (cls == C_BRANCH) || (cls == C_JUMP);
                o.bool_set     = slt_like && (c == 2'd1);
            end
            S_MEMORY: begin
                o.i_or_d        = 1'b1;
                o.mem_read      = (cls == C_LOAD);
                o.mem_write     = (cls == C_STORE);
                o.byte_store_en = (ins == I_SB);
                o.half_store_en = (ins == I_SH);
            end
            S_WRITEBACK: begin
                o.reg_write = 1'b1;
                o.reg_dst   = (cls == C_ALU_R || cls == C_SHIFT) ? `REG_DST_W'(1) : '0;
                if (cls == C_LOAD) begin
                    o.mem_to_reg = `WB_SEL_W'(1);
                    o.mem_read   = 1'b1;
                    case (ins)
                        I_LB:    o.load_mask = `MASK_W'(3);
                        I_LBU:   o.load_mask = `MASK_W'(4);
                        I_LH:    o.load_mask = `MASK_W'(1);
                        I_LHU:   o.load_mask = `MASK_W'(2);
                        default: o.load_mask = '0;
                    endcase
                end else if (slt_like) begin
                    o.mem_to_reg = `WB_SEL_W'(2);
                end
            end
            default: ;
        endcase
        // Extension follows the instruction from execute on.
        if (st inside {S_EXECUTE, S_MEMORY, S_WRITEBACK}) begin
            if (ins == I_LUI) begin
                o.ext_mode = `EXT_W'(3);
            end else if (ins inside {I_ADDIU, I_SLTI, I_SLTIU} ||
                         cls inside {C_LOAD, C_STORE, C_BRANCH}) begin
                o.ext_mode = `EXT_W'(2);
            end
        end
        if (rst) begin
            o.ir_write      = 1'b0;
            o.pc_write      = 1'b0;
            o.alt_pc_write  = 1'b0;
            o.reg_write     = 1'b0;
            o.bool_set      = 1'b0;
            o.mem_read      = 1'b0;
            o.mem_write     = 1'b0;
            o.i_or_d        = 1'b0;
            o.byte_store_en = 1'b0;
            o.half_store_en = 1'b0;
            o.load_mask     = '0;
        end
        return o;
    endfunction

    // Instruction fields as {opcode, function, rt}.
    function automatic logic [ENC_W-1:0] encode(input instr_e ins);
        logic [`OPCODE_W-1:0] op;
        logic [`FUNCT_W-1:0]  fn;
        logic [`RT_W-1:0]     rt;
        op = `OP_SPECIAL;
        fn = '0;
        rt = '0;
        case (ins)
            I_ADDU:  fn = `FN_ADDU;
            I_SUBU:  fn = `FN_SUBU;
            I_AND:   fn = `FN_AND;
            I_OR:    fn = `FN_OR;
            I_XOR:   fn = `FN_XOR;
            I_SLT:   fn = `FN_SLT;
            I_SLTU:  fn = `FN_SLTU;
            I_SLL:   fn = `FN_SLL;
            I_SRL:   fn = `FN_SRL;
            I_SRA:   fn = `FN_SRA;
            I_SLLV:  fn = `FN_SLLV;
            I_SRLV:  fn = `FN_SRLV;
            I_SRAV:  fn = `FN_SRAV;
            I_JR:    fn = `FN_JR;
            I_BLTZ: begin
                op = `OP_REGIMM;
                rt = `RT_BLTZ;
            end
            I_BGEZ: begin
                op = `OP_REGIMM;
                rt = `RT_BGEZ;
            end
            I_J:     op = `OP_J;
            I_BEQ:   op = `OP_BEQ;
            I_BNE:   op = `OP_BNE;
            I_BLEZ:  op = `OP_BLEZ;
            I_BGTZ:  op = `OP_BGTZ;
            I_ADDIU: op = `OP_ADDIU;
            I_SLTI:  op = `OP_SLTI;
            I_SLTIU: op = `OP_SLTIU;
            I_ANDI:  op = `OP_ANDI;
            I_ORI:   op = `OP_ORI;
            I_XORI:  op = `OP_XORI;
            I_LUI:   op = `OP_LUI;
            I_LB:    op = `OP_LB;
            I_LH:    op = `OP_LH;
            I_LW:    op = `OP_LW;
            I_LBU:   op = `OP_LBU;
            I_LHU:   op = `OP_LHU;
            I_SB:    op = `OP_SB;
            I_SH:    op = `OP_SH;
            I_SW:    op = `OP_SW;
            // Unused opcode.
            default: op = 6'h3f;
        endcase
        return {op, fn, rt};
    endfunction

    // ########################################
    // Checking.
    // ########################################
    task automatic check(input string field, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s, %s in %s: expected %0h, actual %0h",
                     test_name, field, exp_state.name(), expected, actual);
            $display("Done: errors found");
            $fatal(1, "output mismatch");
        end
    endtask

    always @(negedge clk) begin
        if (checking) begin
            exp_out = ref_ctrl(exp_instr, exp_state, cond, reset);
            check("ir_write", 32'(exp_out.ir_write), 32'(ir_write));
            check("pc_write", 32'(exp_out.pc_write), 32'(pc_write));
            check("alt_pc_write", 32'(exp_out.alt_pc_write), 32'(alt_pc_write));
            check("pc_src", 32'(exp_out.pc_src), 32'(pc_src));
            check("reg_write", 32'(exp_out.reg_write), 32'(reg_write));
            check("reg_dst", 32'(exp_out.reg_dst), 32'(reg_dst));
            check("mem_to_reg", 32'(exp_out.mem_to_reg), 32'(mem_to_reg));
            check("alu_src_a", 32'(exp_out.alu_src_a), 32'(alu_src_a));
            check("alu_src_b", 32'(exp_out.alu_src_b), 32'(alu_src_b));
            check("alu_op", 32'(exp_out.alu_op), 32'(alu_op));
            check("ext_mode", 32'(exp_out.ext_mode), 32'(ext_mode));
            check("shift_swap", 32'(exp_out.shift_swap), 32'(shift_swap));
            check("bool_set", 32'(exp_out.bool_set), 32'(bool_set));
            check("mem_read", 32'(exp_out.mem_read), 32'(mem_read));
            check("mem_write", 32'(exp_out.mem_write), 32'(mem_write));
            check("i_or_d", 32'(exp_out.i_or_d), 32'(i_or_d));
            check("byte_store_en", 32'(exp_out.byte_store_en), 32'(byte_store_en));
            check("half_store_en", 32'(exp_out.half_store_en), 32'(half_store_en));
            check("load_mask", 32'(exp_out.load_mask), 32'(load_mask));
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $fatal(1, "simulation timed out");
        end
    end

    // ########################################
    // Stimulus.
    // ########################################
    // Runs from the edge that opens fetch to the edge of the next fetch.
    task automatic run_instr(input instr_e ins, input logic [1:0] c, input string label);
        instr_class_e cls;
        cls       = class_of(ins);
        test_name = label;
        {ir_opcode, ir_function, ir_rt} <= encode(ins);
        cond      <= c;
        exp_state <= S_FETCH;
        @(posedge clk);
        exp_state <= S_DECODE;
        @(posedge clk);
        exp_state <= S_EXECUTE;
        exp_instr <= ins;
        // Junk fields once decode has sampled them.
        {ir_opcode, ir_function, ir_rt} <= ENC_W'($urandom);
        if (cls inside {C_LOAD, C_STORE}) begin
            @(posedge clk);
            exp_state <= S_MEMORY;
        end
        if (cls inside {C_LOAD, C_ALU_R, C_ALU_I, C_SHIFT}) begin
            @(posedge clk);
            exp_state <= S_WRITEBACK;
        end
        @(posedge clk);
    endtask

    initial begin
        instr_e     ins;
        logic [1:0] c;
        int         idx;
        void'($urandom(32'h6e8e8f9a));
        @(posedge clk);
        checking <= 1'b1;
        @(posedge clk);
        reset <= 1'b0;

        // Every kept instruction once.
        ins = ins.first();
        do begin
            ins = ins.next();
            c   = 2'($urandom % 4);
            run_instr(ins, c, $sformatf("%s cond=%0d", ins.name(), c));
        end while (ins != ins.last());
        run_instr(I_NOP, 2'd0, "unknown opcode");

        // Random register and shift function codes.
        for (int n = 0; n < N_RANDOM; n++) begin
            idx = int'($urandom % 13);
            ins = r_pool[idx];
            c   = 2'($urandom % 4);
            run_instr(ins, c, $sformatf("random %0d %s cond=%0d", n, ins.name(), c));
        end

        // Set-on-less-than with each compare result.
        for (int s = 0; s < 4; s++) begin
            for (int v = 0; v < 4; v++) begin
                ins = slt_pool[s];
                run_instr(ins, 2'(v), $sformatf("%s cond sweep %0d", ins.name(), v));
            end
        end

        $display("Done: no errors");
        $finish;
    end

endmodule
